/* vlog.f */
+incdir+rtl
rtl/xbar_pkg.sv
rtl/onehot_select.sv
rtl/addr_decoder.sv
rtl/bank_arbiter.sv
rtl/mem_bank.sv
rtl/xbar_top.sv
tb/xbar_props.sv
tb/xbar_tb.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = xbar_tb
FILELIST  = vlog.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb/xbar_tb.sv */
// Crossbar testbench
`timescale 1ns/1ns
`include "xbar_params.svh"
`default_nettype none

module xbar_tb;
    import xbar_pkg::*;

    // Operation counts per test.
    localparam int fill_ops   = 2 * (2**`XBAR_BANK_AW);
    localparam int single_ops = 32;
    localparam int cross_ops  = 32;
    localparam int strobe_ops = 32;
    localparam int busy_ops   = 80;
    localparam int unmap_ops  = 24;
    localparam int total_ops  = fill_ops + single_ops + cross_ops + strobe_ops
        + busy_ops + unmap_ops;

    logic   clk;
    logic   rst;
    logic   cpu_re    [`XBAR_CPUS];
    strb_t  cpu_we    [`XBAR_CPUS];
    waddr_t cpu_addr  [`XBAR_CPUS];
    word_t  cpu_wdata [`XBAR_CPUS];
    logic   cpu_ready [`XBAR_CPUS];
    word_t  cpu_rdata [`XBAR_CPUS];

    // Requests issued and completed per CPU.
    int issued   [`XBAR_CPUS] = '{0, 0};
    int finished [`XBAR_CPUS] = '{0, 0};
    // Cycles since the pending request was presented.
    int age      [`XBAR_CPUS] = '{0, 0};
    // Latency of the last completed request.
    int lat      [`XBAR_CPUS] = '{0, 0};

    // Shadow copy of both banks.
    word_t shadow [`XBAR_MEMS][2**`XBAR_BANK_AW];
    logic [31:0] lfsr = 32'd80934;

    xbar_top dut_i (
        .clk(clk),
        .rst(rst),
        .cpu_re(cpu_re),
        .cpu_we(cpu_we),
        .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_ready(cpu_ready),
        .cpu_rdata(cpu_rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1.
    // Stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [`XBAR_ALEN-1:0] bank_base(input int b);
        if (b == 0) begin
            return `XBAR_BANK0_BASE;
        end
        return `XBAR_BANK1_BASE;
    endfunction

    // Bank holding a word address.
    // Gives -1 outside both windows.
    function automatic int bank_of(input waddr_t a);
        int byte_addr;
        byte_addr = int'({a, 2'b00});
        for (int b = 0; b < `XBAR_MEMS; b++) begin
            if (byte_addr >= int'(bank_base(b))
                && byte_addr < int'(bank_base(b)) + 2**`XBAR_BANK_LOG2) begin
                return b;
            end
        end
        return -1;
    endfunction

    // Shadow word when mapped.
    // Unmapped reads return zero.
    function automatic word_t expected_word(input waddr_t a);
        int b;
        b = bank_of(a);
        if (b < 0) begin
            return '0;
        end
        return shadow[b][a[`XBAR_BANK_AW+1:2]];
    endfunction

    // Random word address inside bank b.
    function automatic waddr_t mapped_addr(input int b);
        logic [`XBAR_ALEN-1:0] byte_addr;
        logic [7:0]            idx;
        idx       = 8'(rand_bits(8));
        byte_addr = bank_base(b) | (16'(idx) << 2);
        return byte_addr[`XBAR_ALEN-1:2];
    endfunction

    function automatic waddr_t unmapped_addr();
        waddr_t a;
        a = waddr_t'(rand_bits(14));
        while (bank_of(a) >= 0) begin
            a = waddr_t'(rand_bits(14));
        end
        return a;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    // Present one request, hold it until ready, then idle one cycle.
    task automatic access(input int c, input logic re, input strb_t we,
                          input waddr_t addr, input word_t wdata, input logic exact);
        @(posedge clk);
        #2;
        cpu_re[c]    = re;
        cpu_we[c]    = we;
        cpu_addr[c]  = addr;
        cpu_wdata[c] = wdata;
        issued[c]    = issued[c] + 1;
        wait (finished[c] == issued[c]);
        // Uncontended requests take exactly one cycle.
        if (exact) begin
            assert (lat[c] == 1) else fail_run($sformatf(
                "CHECK FAILED at %0t: cpu_ready[%0d] latency expected 1 got %0d",
                $time, c, lat[c]));
        end else begin
            assert (lat[c] <= 3) else fail_run($sformatf(
                "CHECK FAILED at %0t: cpu_ready[%0d] latency expected <= 3 got %0d",
                $time, c, lat[c]));
        end
        @(posedge clk);
        #2;
        cpu_re[c] = 1'b0;
        cpu_we[c] = '0;
    endtask

    // Completion tracking and read check at mid-cycle.
    always @(negedge clk) begin
        word_t exp;
        int    b;
        for (int c = 0; c < `XBAR_CPUS; c++) begin
            if (finished[c] != issued[c]) begin
                age[c] = age[c] + 1;
                // Ready in the presenting cycle belongs to the previous request.
                if (age[c] >= 2 && cpu_ready[c]) begin
                    if (cpu_re[c]) begin
                        exp = expected_word(cpu_addr[c]);
                        assert (cpu_rdata[c] === exp) else fail_run($sformatf(
                            "CHECK FAILED at %0t: cpu_rdata[%0d] expected %h got %h",
                            $time, c, exp, cpu_rdata[c]));
                    end
                    // Strobe merge into the shadow.
                    // Unmapped writes are dropped.
                    b = bank_of(cpu_addr[c]);
                    for (int i = 0; i < $bits(strb_t); i++) begin
                        if (cpu_we[c][i] && b >= 0) begin
                            shadow[b][cpu_addr[c][`XBAR_BANK_AW+1:2]][8*i +: 8] =
                                cpu_wdata[c][8*i +: 8];
                        end
                    end
                    lat[c]      = age[c] - 1;
                    age[c]      = 0;
                    finished[c] = finished[c] + 1;
                end
            end
        end
    end

    // Every word gets a pattern of its own byte address.
    task automatic fill_bank(input int c, input int b);
        logic [`XBAR_ALEN-1:0] byte_addr;
        for (int i = 0; i < 2**`XBAR_BANK_AW; i++) begin
            byte_addr = bank_base(b) | (16'(i) << 2);
            access(c, 1'b0, '1, byte_addr[`XBAR_ALEN-1:2], {~byte_addr, byte_addr}, 1'b1);
        end
    endtask

    task automatic random_traffic(input int c);
        waddr_t a;
        strb_t  s;
        for (int i = 0; i < busy_ops / 2; i++) begin
            // Three in four accesses go to bank 0.
            a = mapped_addr((rand_bits(2) == 0) ? 1 : 0);
            if (rand_bits(1) == 1) begin
                access(c, 1'b1, '0, a, '0, 1'b0);
            end else begin
                s = strb_t'(rand_bits(4));
                s = (s == '0) ? strb_t'(1) : s;
                access(c, 1'b0, s, a, word_t'(rand_bits(32)), 1'b0);
            end
        end
    endtask

    initial begin
        waddr_t a;
        waddr_t twin;
        strb_t  s;
        for (int c = 0; c < `XBAR_CPUS; c++) begin
            cpu_re[c]    = 1'b0;
            cpu_we[c]    = '0;
            cpu_addr[c]  = '0;
            cpu_wdata[c] = '0;
        end
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // Both banks filled in parallel, one CPU each.
        fork
            fill_bank(0, 0);
            fill_bank(1, 1);
        join

        // Single CPU write then read back.
        for (int i = 0; i < single_ops / 2; i++) begin
            a = mapped_addr(int'(rand_bits(1)));
            access(0, 1'b0, '1, a, word_t'(rand_bits(32)), 1'b1);
            access(0, 1'b1, '0, a, '0, 1'b1);
        end

        // Writes by one CPU seen by the other.
        for (int i = 0; i < cross_ops / 4; i++) begin
            a = mapped_addr(int'(rand_bits(1)));
            access(0, 1'b0, '1, a, word_t'(rand_bits(32)), 1'b1);
            access(1, 1'b1, '0, a, '0, 1'b1);
            a = mapped_addr(int'(rand_bits(1)));
            access(1, 1'b0, '1, a, word_t'(rand_bits(32)), 1'b1);
            access(0, 1'b1, '0, a, '0, 1'b1);
        end

        // Partial writes.
        for (int i = 0; i < strobe_ops / 2; i++) begin
            a = mapped_addr(int'(rand_bits(1)));
            s = strb_t'(rand_bits(4));
            s = (s == '0) ? strb_t'(1) : s;
            access(i % 2, 1'b0, s, a, word_t'(rand_bits(32)), 1'b1);
            access(i % 2, 1'b1, '0, a, '0, 1'b1);
        end

        fork
            random_traffic(0);
            random_traffic(1);
        join

        // Unmapped read, unmapped write, then the aliased bank word.
        for (int i = 0; i < unmap_ops / 3; i++) begin
            a    = unmapped_addr();
            twin = waddr_t'((bank_base(i % 2) | (16'(a[`XBAR_BANK_AW+1:2]) << 2)) >> 2);
            access(0, 1'b1, '0, a, '0, 1'b1);
            access(1, 1'b0, '1, a, word_t'(rand_bits(32)), 1'b1);
            access(1, 1'b1, '0, twin, '0, 1'b1);
        end

        repeat (2) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

    // Watchdog allows eight cycles per access.
    initial begin
        repeat (total_ops * 8) @(posedge clk);
        fail_run("timeout: the accesses did not all complete in time");
    end

endmodule

`default_nettype wire

/* tb/xbar_props.sv */
// Bank arbiter properties
`timescale 1ns/1ns
`default_nettype none

module xbar_props (
    input logic                clk,
    input logic                rst,
    input xbar_pkg::cpu_mask_t req_valid,
    input xbar_pkg::cpu_mask_t served,
    input xbar_pkg::bank_req_t mem_req
);

    // At most one CPU served per cycle.
    served_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(served))
        else $error("served mask has more than one bit set");

    // Served lags a request by one cycle.
    served_requested: assert property (@(posedge clk) disable iff (rst)
        (served & ~$past(req_valid)) == '0)
        else $error("CPU served without a request in the previous cycle");

    // No enables reach an idle bank.
    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        req_valid == '0 |-> !mem_req.re && mem_req.we == '0)
        else $error("bank enabled with no request present");

endmodule

bind bank_arbiter xbar_props props_i (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .served(served),
    .mem_req(mem_req)
);

`default_nettype wire

/* rtl/xbar_top.sv */
// Two-by-two memory crossbar
`timescale 1ns/1ns
`include "xbar_params.svh"
`default_nettype none

module xbar_top (
    input  logic             clk,
    input  logic             rst,

    // CPU requests.
    input  logic             cpu_re    [`XBAR_CPUS],
    input  xbar_pkg::strb_t  cpu_we    [`XBAR_CPUS],
    input  xbar_pkg::waddr_t cpu_addr  [`XBAR_CPUS],
    input  xbar_pkg::word_t  cpu_wdata [`XBAR_CPUS],

    // CPU responses.
    output logic             cpu_ready [`XBAR_CPUS],
    output xbar_pkg::word_t  cpu_rdata [`XBAR_CPUS]
);
    import xbar_pkg::*;

    // Decoder side, indexed by CPU then bank.
    bank_req_t  dec_req [`XBAR_CPUS][`XBAR_MEMS];
    bank_mask_t dec_sel [`XBAR_CPUS];

    // Arbiter side, indexed by bank then CPU.
    bank_req_t  arb_req   [`XBAR_MEMS][`XBAR_CPUS];
    cpu_mask_t  arb_valid [`XBAR_MEMS];

    // Arbiter outputs, shared by all decoders.
    cpu_mask_t  served    [`XBAR_MEMS];
    word_t      arb_rdata [`XBAR_MEMS];

    // Bank ports.
    bank_req_t  bank_req   [`XBAR_MEMS];
    word_t      bank_rdata [`XBAR_MEMS];

    // One decoder per CPU.
    for (genvar c = 0; c < `XBAR_CPUS; c++) begin : g_cpu
        addr_decoder #(
            .cpu_index(c)
        ) dec_i (
            .clk(clk),
            .rst(rst),
            .re(cpu_re[c]),
            .we(cpu_we[c]),
            .addr(cpu_addr[c]),
            .wdata(cpu_wdata[c]),
            .ready(cpu_ready[c]),
            .rdata(cpu_rdata[c]),
            .bank_req(dec_req[c]),
            .bank_sel(dec_sel[c]),
            .served(served),
            .bank_rdata(arb_rdata)
        );

        // Transpose the grid toward the arbiters.
        for (genvar b = 0; b < `XBAR_MEMS; b++) begin : g_grid
            assign arb_req[b][c]   = dec_req[c][b];
            assign arb_valid[b][c] = dec_sel[c][b];
        end
    end

    // One arbiter and one SRAM per bank.
    for (genvar b = 0; b < `XBAR_MEMS; b++) begin : g_bank
        bank_arbiter arb_i (
            .clk(clk),
            .rst(rst),
            .req_valid(arb_valid[b]),
            .cpu_req(arb_req[b]),
            .mem_req(bank_req[b]),
            .served(served[b]),
            .mem_rdata(bank_rdata[b]),
            .rdata(arb_rdata[b])
        );

        mem_bank mem_i (
            .clk(clk),
            .req(bank_req[b]),
            .rdata(bank_rdata[b])
        );
    end

endmodule

`default_nettype wire

/* rtl/mem_bank.sv */
// Byte-strobed SRAM bank
`timescale 1ns/1ns
`include "xbar_params.svh"
`default_nettype none

module mem_bank (
    input  logic                clk,
    // Request from the arbiter.
    input  xbar_pkg::bank_req_t req,
    // Read data, one cycle after the read.
    output xbar_pkg::word_t     rdata
);
    import xbar_pkg::*;

    // Word storage.
    word_t mem [2**`XBAR_BANK_AW];

    // Word index inside the bank.
    logic [`XBAR_BANK_AW-1:0] idx;

    // Upper bits were already matched by the decoder.
    assign idx = req.addr[`XBAR_BANK_AW+1:2];

    // Strobed bytes land at the edge.
    always_ff @(posedge clk) begin
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (req.we[i]) begin
                mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
            end
        end
    end

    // Registered read, old data when a write hits the same word.
    always_ff @(posedge clk) begin
        if (req.re) begin
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* rtl/bank_arbiter.sv */
// Round-robin bank arbiter
`timescale 1ns/1ns
`include "xbar_params.svh"
`default_nettype none

module bank_arbiter (
    input  logic                clk,
    input  logic                rst,

    // Which CPUs want this bank.
    input  xbar_pkg::cpu_mask_t req_valid,
    // Requests from every decoder.
    input  xbar_pkg::bank_req_t cpu_req [`XBAR_CPUS],

    // Request forwarded to the bank.
    output xbar_pkg::bank_req_t mem_req,
    // CPU granted in the previous cycle.
    output xbar_pkg::cpu_mask_t served,

    // Read data from the bank and to the decoders.
    input  xbar_pkg::word_t     mem_rdata,
    output xbar_pkg::word_t     rdata
);
    import xbar_pkg::*;

    // Current owner of the bank, always one-hot.
    cpu_mask_t cur;
    // Grant for this cycle.
    cpu_mask_t grant;
    // Set once a successor has been picked.
    logic      found;

    // Owner keeps custody while it keeps requesting.
    // Otherwise walk forward from the owner, wrapping around.
    always_comb begin
        grant = '0;
        found = 1'b0;
        if ((cur & req_valid) != '0) begin
            grant = cur;
        end else begin
            for (int k = 1; k < `XBAR_CPUS; k++) begin
                for (int j = 0; j < `XBAR_CPUS; j++) begin
                    if (!found && cur[j] && req_valid[(j + k) % `XBAR_CPUS]) begin
                        grant[(j + k) % `XBAR_CPUS] = 1'b1;
                        found = 1'b1;
                    end
                end
            end
        end
    end

    // Ownership moves only when someone was granted.
    // Served lags the grant by one cycle, matching the bank latency.
    always_ff @(posedge clk) begin
        if (rst) begin
            cur    <= cpu_mask_t'(1);
            served <= '0;
        end else begin
            if (grant != '0) begin
                cur <= grant;
            end
            served <= grant;
        end
    end

    // Only the granted request reaches the bank.
    onehot_select #(
        .payload_t(bank_req_t),
        .N(`XBAR_CPUS)
    ) req_sel_i (
        .sel(grant),
        .din(cpu_req),
        .dout(mem_req)
    );

    // Bank data goes to all decoders.
    // Each one filters by its own served bit.
    assign rdata = mem_rdata;

endmodule

`default_nettype wire

/* rtl/addr_decoder.sv */
// CPU-side address decoder
`timescale 1ns/1ns
`include "xbar_params.svh"
`default_nettype none

module addr_decoder #(
    // Bit of this CPU in the arbiters' served masks.
    parameter int cpu_index = 0
) (
    input  logic                clk,
    input  logic                rst,

    // CPU request.
    input  logic                re,
    input  xbar_pkg::strb_t     we,
    input  xbar_pkg::waddr_t    addr,
    input  xbar_pkg::word_t     wdata,

    // CPU response, one cycle after the request.
    output logic                ready,
    output xbar_pkg::word_t     rdata,

    // Requests toward every bank arbiter.
    output xbar_pkg::bank_req_t bank_req [`XBAR_MEMS],
    output xbar_pkg::bank_mask_t bank_sel,

    // Served masks and read data from the arbiters.
    input  xbar_pkg::cpu_mask_t served [`XBAR_MEMS],
    input  xbar_pkg::word_t     bank_rdata [`XBAR_MEMS]
);
    import xbar_pkg::*;

    // Fixed bank windows.
    localparam logic [`XBAR_ALEN-1:0] bank_base [`XBAR_MEMS] = '{
        `XBAR_BANK0_BASE,
        `XBAR_BANK1_BASE
    };

    // Window hits before gating.
    bank_mask_t hit;
    // Any access present this cycle.
    logic       active;
    // Bank selection of the previous cycle.
    bank_mask_t r_sel;

    assign active = re | (|we);

    for (genvar b = 0; b < `XBAR_MEMS; b++) begin : g_bank
        // Compare the bits above the bank window.
        assign hit[b] = addr[`XBAR_ALEN-1:`XBAR_BANK_LOG2]
            == bank_base[b][`XBAR_ALEN-1:`XBAR_BANK_LOG2];
        assign bank_sel[b] = hit[b] & active;

        // Enables only reach the bank that was hit.
        assign bank_req[b] = '{
            re:    re & bank_sel[b],
            we:    we & {$bits(strb_t){bank_sel[b]}},
            addr:  addr,
            wdata: wdata
        };
    end

    // Remember where the request went, to route the response.
    always_ff @(posedge clk) begin
        if (rst) begin
            r_sel <= '0;
        end else begin
            r_sel <= bank_sel;
        end
    end

    // Idle or unmapped requests complete at once.
    // Otherwise wait until the selected bank served us.
    always_comb begin
        ready = 1'b0;
        if (r_sel == '0) begin
            ready = 1'b1;
        end else begin
            for (int b = 0; b < `XBAR_MEMS; b++) begin
                ready = ready | (r_sel[b] & served[b][cpu_index]);
            end
        end
    end

    // Read data from the selected bank, zero when unmapped.
    onehot_select #(
        .payload_t(word_t),
        .N(`XBAR_MEMS)
    ) rdata_sel_i (
        .sel(r_sel),
        .din(bank_rdata),
        .dout(rdata)
    );

endmodule

`default_nettype wire

/* rtl/onehot_select.sv */
// One-hot AND-OR selector
`timescale 1ns/1ns
`default_nettype none

module onehot_select #(
    // Payload carried through the selector.
    parameter type payload_t = logic,
    // Number of inputs.
    parameter int N = 2
) (
    // One-hot or zero select mask.
    input  logic [N-1:0] sel,
    // Candidate payloads.
    input  payload_t     din [N],
    // Selected payload.
    output payload_t     dout
);

    // Accumulate every selected input.
    // Zero mask gives an all-zero payload.
    always_comb begin
        dout = '0;
        for (int i = 0; i < N; i++) begin
            if (sel[i]) begin
                dout = dout | din[i];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/xbar_pkg.sv */
// Crossbar shared types
`include "xbar_params.svh"
`default_nettype none

package xbar_pkg;

    // One data word.
    typedef logic [`XBAR_DLEN-1:0] word_t;

    // Byte write strobes, one per lane.
    typedef logic [`XBAR_DLEN/8-1:0] strb_t;

    // Word address, byte offset bits dropped.
    typedef logic [`XBAR_ALEN-1:2] waddr_t;

    // One bit per CPU port.
    typedef logic [`XBAR_CPUS-1:0] cpu_mask_t;

    // One bit per bank.
    typedef logic [`XBAR_MEMS-1:0] bank_mask_t;

    // Request as seen by a bank.
    // Zero in every field means idle.
    typedef struct packed {
        // Read enable.
        logic   re;
        // Byte write strobes.
        strb_t  we;
        // Word address.
        waddr_t addr;
        // Write data.
        word_t  wdata;
    } bank_req_t;

endpackage

`default_nettype wire

/* rtl/xbar_params.svh */
// Crossbar sizing and bank windows
`ifndef XBAR_PARAMS_SVH
`define XBAR_PARAMS_SVH

// Byte address width of the CPU ports.
`define XBAR_ALEN 16
// Data word width, four byte lanes.
`define XBAR_DLEN 32

// CPU ports on the crossbar.
`define XBAR_CPUS 2
// SRAM banks behind the crossbar.
`define XBAR_MEMS 2

// Word address bits inside one bank, 256 words.
`define XBAR_BANK_AW 8

// Bank base byte addresses, naturally aligned.
`define XBAR_BANK0_BASE 16'h0000
`define XBAR_BANK1_BASE 16'h1000

// Bank size in bytes as log2.
`define XBAR_BANK_LOG2 10

`endif
